/* cub_alu_pkg.sv */
package cub_alu_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int WORD_W     = 32;
    localparam int RF_ADDR_W  = 5;
    localparam int RF_DEPTH   = 32;
    localparam int CSR_ADDR_W = 4;
    localparam int CSR_DATA_W = 16;
    localparam int SHIFT_W    = 5;
    localparam int LAMBDA_W   = 16;
    localparam int IMM_W      = 12;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [RF_ADDR_W-1:0]  rf_addr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;
    typedef logic [SHIFT_W-1:0]    shift_t;
    typedef logic [LAMBDA_W-1:0]   lambda_t;   // signed scale

    // low two opcode bits line up with the arith operator
    typedef enum logic [1:0] {
        ARITH_ADD = 2'd0,
        ARITH_SUB = 2'd1,
        ARITH_MAX = 2'd2,
        ARITH_MIN = 2'd3
    } arith_op_e;

    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_MAX = 4'h2,
        OP_MIN = 4'h3,
        OP_MUL = 4'h4,
        OP_LI  = 4'h5,
        OP_OUT = 4'h6,
        OP_NOP = 4'hf
    } instr_op_e;

    // ============================================================
    // csr map and crossbar channels
    // ============================================================
    localparam csr_addr_t CSR_MODE   = 4'd0;
    localparam csr_addr_t CSR_BIAS   = 4'd1;
    localparam csr_addr_t CSR_SHIFT  = 4'd2;
    localparam csr_addr_t CSR_LAMBDA = 4'd3;
    localparam csr_addr_t CSR_XBAR   = 4'd4;

    localparam int XBAR_CH_IN  = 4;
    localparam int XBAR_CH_OUT = 3;
    localparam int XBAR_MASK_W = XBAR_CH_IN * XBAR_CH_OUT;

    localparam int XIN_STREAM = 0;
    localparam int XIN_RF     = 1;
    localparam int XIN_MULT   = 2;
    localparam int XIN_ARITH  = 3;

    localparam int XOUT_MULT  = 0;
    localparam int XOUT_ARITH = 1;
    localparam int XOUT_PORT  = 2;

endpackage

/* cub_alu_tb.sv */
`timescale 1ns/10ps
module cub_alu_tb;

    logic                   clk;
    logic                   rst_n;
    cub_alu_pkg::word_t     data_i;
    logic                   data_valid_i;
    cub_alu_pkg::word_t     data_o;
    logic                   data_valid_o;
    cub_alu_pkg::word_t     instr_i;
    logic                   instr_valid_i;
    logic                   deassert_we_i;
    logic                   csr_access_i;
    cub_alu_pkg::csr_addr_t csr_addr_i;
    cub_alu_pkg::csr_data_t csr_wdata_i;

    cub_alu_pkg::word_t     exp_q[$];           // expected port words, oldest first
    cub_alu_pkg::word_t     exp_word;
    int                     seed;

    cub_alu_top #(
        .CH_IN  (cub_alu_pkg::XBAR_CH_IN),
        .CH_OUT (cub_alu_pkg::XBAR_CH_OUT)
    ) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_i        (data_i),
        .data_valid_i  (data_valid_i),
        .data_o        (data_o),
        .data_valid_o  (data_valid_o),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .deassert_we_i (deassert_we_i),
        .csr_access_i  (csr_access_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    // ============================================================
    // drive helpers, all on the falling edge
    // ============================================================
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic release_strobes();
        data_valid_i  = 1'b0;
        instr_valid_i = 1'b0;
        deassert_we_i = 1'b0;
        csr_access_i  = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            release_strobes();
        end
    endtask

    task automatic csr_write(input cub_alu_pkg::csr_addr_t addr,
                             input cub_alu_pkg::csr_data_t wdata);
        @(negedge clk);
        release_strobes();
        csr_access_i = 1'b1;
        csr_addr_i   = addr;
        csr_wdata_i  = wdata;
    endtask

    task automatic issue_instr(input cub_alu_pkg::word_t instr, input logic we_off);
        @(negedge clk);
        release_strobes();
        instr_valid_i = 1'b1;
        instr_i       = instr;
        deassert_we_i = we_off;                 // suppress the rd write
    endtask

    task automatic stream_word(input cub_alu_pkg::word_t word);
        int gap;
        gap = $unsigned($random(seed)) % 3;
        idle_cycles(gap);                       // random gap before the word
        @(negedge clk);
        release_strobes();
        data_i       = word;
        data_valid_i = 1'b1;
    endtask

    // output monitor, port is stable on the falling edge
    always @(negedge clk) begin
        if (data_valid_o === 1'b1) begin
            assert (exp_q.size() != 0)
            else stop_on_error($sformatf("output word %h arrived with nothing expected", data_o));
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                assert (data_o === exp_word)
                else stop_on_error($sformatf("FAIL data_o expected %h got %h",
                                             exp_word, data_o));
            end
        end
    end

    // ============================================================
    // trace replay
    // ============================================================
    initial begin : stimulus
        int            fd;
        int            n;
        int            waited;
        logic [7:0]    kind;
        logic [31:0]   val;
        logic [31:0]   arg;
        logic [1023:0] rest;                    // remainder of a comment line
        bit            done;

        seed        = 65595;
        rst_n       = 1'b0;
        data_i      = '0;
        instr_i     = '0;
        csr_addr_i  = '0;
        csr_wdata_i = '0;
        release_strobes();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("cub_alu_trace.txt", "r");
        if (fd == 0)
            stop_on_error("cannot open cub_alu_trace.txt");
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                done = 1'b1;                    // end of file
            end else begin
                case (kind)
                    "#": n = $fgets(rest, fd);
                    "C": begin
                        n = $fscanf(fd, "%h %h", val, arg);
                        csr_write(val[3:0], arg[15:0]);
                    end
                    "I": begin
                        n = $fscanf(fd, "%h %h", val, arg);
                        issue_instr(val, arg[0]);
                    end
                    "S": begin
                        n = $fscanf(fd, "%h", val);
                        stream_word(val);
                    end
                    "W": begin
                        n = $fscanf(fd, "%d", val);
                        idle_cycles(val);
                    end
                    "E": begin
                        n = $fscanf(fd, "%h", val);
                        exp_q.push_back(val);
                    end
                    default: stop_on_error($sformatf("unknown trace line kind %s", kind));
                endcase
                if (n < 1)
                    stop_on_error("malformed line in cub_alu_trace.txt");
            end
        end
        $fclose(fd);
        idle_cycles(1);

        // drain the pipeline, bounded
        waited = 0;
        while (exp_q.size() != 0 && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() == 0) begin
            repeat (4) @(posedge clk);          // room for stray words
            $display("All checks passed");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d expected output words never arrived", exp_q.size()));
        end
    end

endmodule

/* cub_alu_top.f */
cub_alu_pkg.sv
cub_csr_regs.sv
cub_id_stage.sv
cub_arith.sv
cub_mult.sv
cub_crossbar.sv
cub_alu_top.sv
cub_alu_tb.sv

/* cub_alu_top.sv */
`timescale 1ns/10ps
module cub_alu_top #(
    parameter int CH_IN  = cub_alu_pkg::XBAR_CH_IN,
    parameter int CH_OUT = cub_alu_pkg::XBAR_CH_OUT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cub_alu_pkg::word_t     data_i,
    input  logic                   data_valid_i,
    output cub_alu_pkg::word_t     data_o,
    output logic                   data_valid_o,
    input  cub_alu_pkg::word_t     instr_i,
    input  logic                   instr_valid_i,
    input  logic                   deassert_we_i,
    input  logic                   csr_access_i,
    input  cub_alu_pkg::csr_addr_t csr_addr_i,
    input  cub_alu_pkg::csr_data_t csr_wdata_i
);

    // csr fields
    logic                   cflow_mode;
    cub_alu_pkg::arith_op_e cflow_op;
    cub_alu_pkg::word_t     arith_bias;
    cub_alu_pkg::shift_t    arith_shift;
    cub_alu_pkg::shift_t    mult_shift;
    cub_alu_pkg::lambda_t   mult_lambda;
    logic [CH_IN*CH_OUT-1:0] xbar_mask;

    // id/ex
    logic                   alu_en;
    logic                   mult_en;
    cub_alu_pkg::arith_op_e alu_op;
    cub_alu_pkg::word_t     operand_a;
    cub_alu_pkg::word_t     operand_b;
    cub_alu_pkg::word_t     rf_out;
    logic                   rf_out_valid;

    // unit results and crossbar
    cub_alu_pkg::word_t     arith_rslt;
    cub_alu_pkg::word_t     mult_rslt;
    logic                   arith_rslt_valid;
    logic                   mult_rslt_valid;
    cub_alu_pkg::word_t [CH_IN-1:0]  xin_data;
    logic [CH_IN-1:0]                xin_valid;
    cub_alu_pkg::word_t [CH_OUT-1:0] xout_data;
    logic [CH_OUT-1:0]               xout_valid;

    assign xin_data[cub_alu_pkg::XIN_STREAM]  = data_i;
    assign xin_valid[cub_alu_pkg::XIN_STREAM] = data_valid_i;
    assign xin_data[cub_alu_pkg::XIN_RF]      = rf_out;
    assign xin_valid[cub_alu_pkg::XIN_RF]     = rf_out_valid;
    assign xin_data[cub_alu_pkg::XIN_MULT]    = mult_rslt;
    assign xin_valid[cub_alu_pkg::XIN_MULT]   = mult_rslt_valid;
    assign xin_data[cub_alu_pkg::XIN_ARITH]   = arith_rslt;
    assign xin_valid[cub_alu_pkg::XIN_ARITH]  = arith_rslt_valid;

    // ============================================================
    // blocks
    // ============================================================
    cub_csr_regs u_csr_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_access_i  (csr_access_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i),
        .cflow_mode_o  (cflow_mode),
        .arith_op_o    (cflow_op),
        .arith_bias_o  (arith_bias),
        .arith_shift_o (arith_shift),
        .mult_shift_o  (mult_shift),
        .mult_lambda_o (mult_lambda),
        .xbar_mask_o   (xbar_mask)
    );

    cub_id_stage u_id_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_i        (instr_i),
        .instr_valid_i  (instr_valid_i),
        .deassert_we_i  (deassert_we_i),
        .alu_en_o       (alu_en),
        .alu_op_o       (alu_op),
        .mult_en_o      (mult_en),
        .operand_a_o    (operand_a),
        .operand_b_o    (operand_b),
        .rf_out_o       (rf_out),
        .rf_out_valid_o (rf_out_valid),
        .alu_rslt_i     (arith_rslt),
        .mult_rslt_i    (mult_rslt)
    );

    cub_arith u_arith (
        .clk           (clk),
        .rst_n         (rst_n),
        .cflow_mode_i  (cflow_mode),
        .instr_en_i    (alu_en),
        .instr_op_i    (alu_op),
        .operand_a_i   (operand_a),
        .operand_b_i   (operand_b),
        .cflow_data_i  (xout_data[cub_alu_pkg::XOUT_ARITH]),
        .cflow_valid_i (xout_valid[cub_alu_pkg::XOUT_ARITH]),
        .cflow_op_i    (cflow_op),
        .bias_i        (arith_bias),
        .shift_i       (arith_shift),
        .rslt_o        (arith_rslt),
        .rslt_valid_o  (arith_rslt_valid)
    );

    cub_mult u_mult (
        .clk           (clk),
        .rst_n         (rst_n),
        .cflow_mode_i  (cflow_mode),
        .instr_en_i    (mult_en),
        .operand_a_i   (operand_a),
        .operand_b_i   (operand_b),
        .cflow_data_i  (xout_data[cub_alu_pkg::XOUT_MULT]),
        .cflow_valid_i (xout_valid[cub_alu_pkg::XOUT_MULT]),
        .lambda_i      (mult_lambda),
        .shift_i       (mult_shift),
        .rslt_o        (mult_rslt),
        .rslt_valid_o  (mult_rslt_valid)
    );

    cub_crossbar #(
        .CH_IN  (CH_IN),
        .CH_OUT (CH_OUT)
    ) u_crossbar (
        .clk          (clk),
        .rst_n        (rst_n),
        .mask_i       (xbar_mask),
        .data_in_i    (xin_data),
        .valid_in_i   (xin_valid),
        .data_out_o   (xout_data),
        .valid_out_o  (xout_valid),
        .port_data_o  (data_o),         // registered port
        .port_valid_o (data_valid_o)
    );

endmodule

/* cub_alu_trace.txt */
# C csr_addr data | I instr deassert_we | S stream word | E expected word | W idle cycles
# values in hex except the W count, which is decimal
# instruction mode with the rf stream routed to the port
C 4 200
I 50800123 0
I 51000FFB 0
I 01844000 0
I 12044000 0
I 22844000 0
I 33044000 0
I 43844000 0
I 00844000 1
W 4
I 600C0000 0
E 0000011E
I 60100000 0
E 00000128
I 60140000 0
E 00000123
I 60180000 0
E FFFFFFFB
I 601C0000 0
E FFFFFA51
I 60040000 0
E 00000123
W 4
# cflow pass-through
C 0 1
C 4 100
S 12345678
E 12345678
S DEADBEEF
E DEADBEEF
W 4
# bias -16, arith shift 2, mult shift 4, lambda -3
C 1 FFF0
C 2 82
C 3 FFFD
C 4 810
S 00000100
E 0000003C
S FFFFFF00
E FFFFFFBC
W 4
C 4 401
S 00000100
E FFFFFFD0
S 00001234
E FFFFFC96
S 40000000
E F4000000
W 4
# chain of stream to mult to arith to port
C 4 841
S 00000100
E FFFFFFF0
S 00001234
E FFFFFF21
W 4

/* cub_arith.sv */
`timescale 1ns/10ps
module cub_arith (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cflow_mode_i,
    input  logic                   instr_en_i,
    input  cub_alu_pkg::arith_op_e instr_op_i,
    input  cub_alu_pkg::word_t     operand_a_i,
    input  cub_alu_pkg::word_t     operand_b_i,
    input  cub_alu_pkg::word_t     cflow_data_i,
    input  logic                   cflow_valid_i,
    input  cub_alu_pkg::arith_op_e cflow_op_i,
    input  cub_alu_pkg::word_t     bias_i,
    input  cub_alu_pkg::shift_t    shift_i,
    output cub_alu_pkg::word_t     rslt_o,
    output logic                   rslt_valid_o
);

    cub_alu_pkg::word_t     op_a;
    cub_alu_pkg::word_t     op_b;
    cub_alu_pkg::arith_op_e op_sel;
    cub_alu_pkg::word_t     raw;
    logic signed [cub_alu_pkg::WORD_W-1:0] raw_shr;
    cub_alu_pkg::word_t     rslt_next;
    logic                   en;

    // stream side uses the csr bias and operator
    assign op_a   = cflow_mode_i ? cflow_data_i : operand_a_i;
    assign op_b   = cflow_mode_i ? bias_i : operand_b_i;
    assign op_sel = cflow_mode_i ? cflow_op_i : instr_op_i;
    assign en     = cflow_mode_i ? cflow_valid_i : instr_en_i;

    always_comb begin
        case (op_sel)
            cub_alu_pkg::ARITH_ADD: raw = op_a + op_b;
            cub_alu_pkg::ARITH_SUB: raw = op_a - op_b;
            cub_alu_pkg::ARITH_MAX: raw = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
            default:                raw = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
        endcase
    end

    // truncation only on the stream path
    assign raw_shr   = $signed(raw) >>> shift_i;
    assign rslt_next = cflow_mode_i ? raw_shr : raw;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rslt_valid_o <= 1'b0;
        else
            rslt_valid_o <= cflow_mode_i & cflow_valid_i;
    end

    always_ff @(posedge clk) begin
        if (en)
            rslt_o <= rslt_next;
    end

endmodule

/* cub_crossbar.sv */
`timescale 1ns/10ps
module cub_crossbar #(
    parameter int CH_IN  = cub_alu_pkg::XBAR_CH_IN,
    parameter int CH_OUT = cub_alu_pkg::XBAR_CH_OUT
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [CH_IN*CH_OUT-1:0]             mask_i,
    input  cub_alu_pkg::word_t [CH_IN-1:0]      data_in_i,
    input  logic [CH_IN-1:0]                    valid_in_i,
    output cub_alu_pkg::word_t [CH_OUT-1:0]     data_out_o,
    output logic [CH_OUT-1:0]                   valid_out_o,
    output cub_alu_pkg::word_t                  port_data_o,
    output logic                                port_valid_o
);

    // ============================================================
    // and-or merge, mask slice k covers inputs of output k
    // ============================================================
    always_comb begin
        data_out_o  = '0;
        valid_out_o = '0;
        for (int k = 0; k < CH_OUT; k++) begin
            for (int i = 0; i < CH_IN; i++) begin
                data_out_o[k]  = data_out_o[k]
                               | (data_in_i[i] & {cub_alu_pkg::WORD_W{mask_i[k*CH_IN+i]}});
                valid_out_o[k] = valid_out_o[k] | (valid_in_i[i] & mask_i[k*CH_IN+i]);
            end
        end
    end

    // last output channel goes off-chip through a register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            port_valid_o <= 1'b0;
        else
            port_valid_o <= valid_out_o[CH_OUT-1];
    end

    always_ff @(posedge clk) begin
        if (valid_out_o[CH_OUT-1])
            port_data_o <= data_out_o[CH_OUT-1];
    end

endmodule

/* cub_csr_regs.sv */
`timescale 1ns/10ps
module cub_csr_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 csr_access_i,
    input  cub_alu_pkg::csr_addr_t               csr_addr_i,
    input  cub_alu_pkg::csr_data_t               csr_wdata_i,
    output logic                                 cflow_mode_o,
    output cub_alu_pkg::arith_op_e               arith_op_o,
    output cub_alu_pkg::word_t                   arith_bias_o,
    output cub_alu_pkg::shift_t                  arith_shift_o,
    output cub_alu_pkg::shift_t                  mult_shift_o,
    output cub_alu_pkg::lambda_t                 mult_lambda_o,
    output logic [cub_alu_pkg::XBAR_MASK_W-1:0]  xbar_mask_o
);

    logic [2:0]                          mode_q;    // op in 2:1, cflow in 0
    cub_alu_pkg::csr_data_t              bias_q;
    logic [2*cub_alu_pkg::SHIFT_W-1:0]   shift_q;   // mult shift on top
    cub_alu_pkg::lambda_t                lambda_q;
    logic [cub_alu_pkg::XBAR_MASK_W-1:0] xbar_q;

    // ============================================================
    // write decode
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q   <= '0;
            bias_q   <= '0;
            shift_q  <= '0;
            lambda_q <= '0;
            xbar_q   <= '0;
        end else if (csr_access_i) begin
            case (csr_addr_i)
                cub_alu_pkg::CSR_MODE:   mode_q   <= csr_wdata_i[2:0];
                cub_alu_pkg::CSR_BIAS:   bias_q   <= csr_wdata_i;
                cub_alu_pkg::CSR_SHIFT:  shift_q  <= csr_wdata_i[2*cub_alu_pkg::SHIFT_W-1:0];
                cub_alu_pkg::CSR_LAMBDA: lambda_q <= csr_wdata_i;
                cub_alu_pkg::CSR_XBAR:   xbar_q   <= csr_wdata_i[cub_alu_pkg::XBAR_MASK_W-1:0];
                default: ;                          // unmapped, write dropped
            endcase
        end
    end

    // field unpacking
    assign cflow_mode_o  = mode_q[0];
    assign arith_op_o    = cub_alu_pkg::arith_op_e'(mode_q[2:1]);
    assign arith_bias_o  = {{(cub_alu_pkg::WORD_W-cub_alu_pkg::CSR_DATA_W){bias_q[15]}}, bias_q};
    assign arith_shift_o = shift_q[cub_alu_pkg::SHIFT_W-1:0];
    assign mult_shift_o  = shift_q[2*cub_alu_pkg::SHIFT_W-1:cub_alu_pkg::SHIFT_W];
    assign mult_lambda_o = lambda_q;
    assign xbar_mask_o   = xbar_q;

endmodule

/* cub_id_stage.sv */
`timescale 1ns/10ps
module cub_id_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cub_alu_pkg::word_t     instr_i,
    input  logic                   instr_valid_i,
    input  logic                   deassert_we_i,
    output logic                   alu_en_o,
    output cub_alu_pkg::arith_op_e alu_op_o,
    output logic                   mult_en_o,
    output cub_alu_pkg::word_t     operand_a_o,
    output cub_alu_pkg::word_t     operand_b_o,
    output cub_alu_pkg::word_t     rf_out_o,
    output logic                   rf_out_valid_o,
    input  cub_alu_pkg::word_t     alu_rslt_i,
    input  cub_alu_pkg::word_t     mult_rslt_i
);

    localparam int IMM_W = cub_alu_pkg::IMM_W;

    cub_alu_pkg::instr_op_e opcode;
    cub_alu_pkg::rf_addr_t  rd;
    cub_alu_pkg::rf_addr_t  rs1;
    cub_alu_pkg::rf_addr_t  rs2;
    cub_alu_pkg::word_t     imm_sext;
    cub_alu_pkg::arith_op_e dec_op;
    logic                   is_arith;
    logic                   is_mul;
    logic                   is_li;
    logic                   is_out;

    cub_alu_pkg::word_t     rf [cub_alu_pkg::RF_DEPTH];

    // pending destination, one stage per cycle until writeback
    cub_alu_pkg::rf_addr_t  ex_rd;
    cub_alu_pkg::rf_addr_t  wb_rd;
    logic                   ex_we;
    logic                   wb_we;
    logic                   ex_mul;
    logic                   wb_mul;

    assign opcode   = cub_alu_pkg::instr_op_e'(instr_i[31:28]);
    assign rd       = instr_i[27:23];
    assign rs1      = instr_i[22:18];
    assign rs2      = instr_i[17:13];
    assign imm_sext = {{(cub_alu_pkg::WORD_W-IMM_W){instr_i[IMM_W-1]}}, instr_i[IMM_W-1:0]};

    // ============================================================
    // decode
    // ============================================================
    always_comb begin
        is_arith = 1'b0;
        is_mul   = 1'b0;
        is_li    = 1'b0;
        is_out   = 1'b0;
        dec_op   = cub_alu_pkg::ARITH_ADD;
        if (instr_valid_i) begin
            case (opcode)
                cub_alu_pkg::OP_ADD,
                cub_alu_pkg::OP_SUB,
                cub_alu_pkg::OP_MAX,
                cub_alu_pkg::OP_MIN: begin
                    is_arith = 1'b1;
                    dec_op   = cub_alu_pkg::arith_op_e'(opcode[1:0]);
                end
                cub_alu_pkg::OP_MUL: is_mul = 1'b1;
                cub_alu_pkg::OP_LI:  is_li  = 1'b1;
                cub_alu_pkg::OP_OUT: is_out = 1'b1;
                default: ;                          // nop and unknown
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_en_o       <= 1'b0;
            mult_en_o      <= 1'b0;
            alu_op_o       <= cub_alu_pkg::ARITH_ADD;
            rf_out_valid_o <= 1'b0;
            ex_rd          <= '0;
            ex_we          <= 1'b0;
            ex_mul         <= 1'b0;
            wb_rd          <= '0;
            wb_we          <= 1'b0;
            wb_mul         <= 1'b0;
        end else begin
            alu_en_o       <= is_arith;
            mult_en_o      <= is_mul;
            rf_out_valid_o <= is_out;                // one-cycle strobe
            ex_we          <= (is_arith | is_mul) & ~deassert_we_i;
            if (is_arith | is_mul) begin
                alu_op_o <= dec_op;
                ex_rd    <= rd;
                ex_mul   <= is_mul;
            end
            wb_rd  <= ex_rd;                        // unit result lands here
            wb_we  <= ex_we;
            wb_mul <= ex_mul;
        end
    end

    // register file and operand latches
    always_ff @(posedge clk) begin
        if (is_arith | is_mul) begin
            operand_a_o <= rf[rs1];
            operand_b_o <= rf[rs2];
        end
        if (is_out)
            rf_out_o <= rf[rs1];
        if (wb_we)
            rf[wb_rd] <= wb_mul ? mult_rslt_i : alu_rslt_i;
        if (is_li && !deassert_we_i)
            rf[rd] <= imm_sext;
    end

endmodule

/* cub_mult.sv */
`timescale 1ns/10ps
module cub_mult (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cflow_mode_i,
    input  logic                 instr_en_i,
    input  cub_alu_pkg::word_t   operand_a_i,
    input  cub_alu_pkg::word_t   operand_b_i,
    input  cub_alu_pkg::word_t   cflow_data_i,
    input  logic                 cflow_valid_i,
    input  cub_alu_pkg::lambda_t lambda_i,
    input  cub_alu_pkg::shift_t  shift_i,
    output cub_alu_pkg::word_t   rslt_o,
    output logic                 rslt_valid_o
);

    localparam int W = cub_alu_pkg::WORD_W;

    cub_alu_pkg::word_t   op_a;
    cub_alu_pkg::word_t   op_b;
    logic signed [2*W-1:0] product;
    logic signed [2*W-1:0] prod_shr;
    logic                 en;

    assign op_a = cflow_mode_i ? cflow_data_i : operand_a_i;
    assign op_b = cflow_mode_i ? {{(W-cub_alu_pkg::LAMBDA_W){lambda_i[15]}}, lambda_i}
                               : operand_b_i;
    assign en   = cflow_mode_i ? cflow_valid_i : instr_en_i;

    // full 64-bit signed product, low word kept
    assign product  = $signed(op_a) * $signed(op_b);
    assign prod_shr = product >>> shift_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rslt_valid_o <= 1'b0;
        else
            rslt_valid_o <= cflow_mode_i & cflow_valid_i;
    end

    always_ff @(posedge clk) begin
        if (en)
            rslt_o <= cflow_mode_i ? prod_shr[W-1:0] : product[W-1:0];
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/10ps --top-module cub_alu_tb \
    -f cub_alu_top.f -o cub_alu_sim
./obj_dir/cub_alu_sim
